/* design/wht_bank_ram.sv */
/*
 * WHT data bank
 * Simple dual-port RAM, one row per point pair, registered read
 */
`timescale 1ns/1ps

module wht_bank_ram (
	input  logic             clk,
	input  wht_pkg::ram_wr_t wr,
	input  wht_pkg::ram_rd_t rd,
	output wht_pkg::word_t   q
);
	import wht_pkg::*;

	// Half of the largest transform
	word_t mem [0:2**ROW_W-1];

	// Write port
	always_ff @(posedge clk) begin
		if (wr.en) begin
			mem[wr.row] <= wr.data;
		end
	end

	// Read port, one cycle of latency, holds when idle
	always_ff @(posedge clk) begin
		if (rd.en) begin
			q <= mem[rd.row];
		end
	end

endmodule

/* design/wht_butterfly.sv */
/*
 * Radix-2 WHT butterfly
 * Registered sum and difference of one pair per cycle
 */
`timescale 1ns/1ps

module wht_butterfly (
	input  logic            clk,
	input  logic            rst_n,
	input  wht_pkg::pair_t  in_pair,
	output wht_pkg::pair_t  out_pair
);

	// One cycle of latency
	always_ff @(posedge clk) begin
		// Payload only moves with valid data
		if (in_pair.valid) begin
			out_pair.a <= in_pair.a + in_pair.b;
			out_pair.b <= in_pair.a - in_pair.b;
		end
		if (!rst_n) begin
			out_pair.valid <= 1'b0;
		end else begin
			out_pair.valid <= in_pair.valid;
		end
	end

endmodule

/* design/wht_engine.sv */
/*
 * WHT engine top
 * Memory controller with the radix-2 butterfly core beside it
 */
`timescale 1ns/1ps

module wht_engine (
	input  logic                clk,
	input  logic                rst_n,
	input  wht_pkg::sink_beat_t in_beat,
	output wht_pkg::out_beat_t  out_beat,
	output logic                sink_ready
);
	import wht_pkg::*;

	// Operands out, results back
	pair_t to_core;
	pair_t from_core;

	wht_mem_ctrl i_mem_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_beat    (in_beat),
		.from_core  (from_core),
		.to_core    (to_core),
		.out_beat   (out_beat),
		.sink_ready (sink_ready)
	);

	wht_butterfly i_butterfly (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_pair  (to_core),
		.out_pair (from_core)
	);

endmodule

/* design/wht_mem_ctrl.sv */
/*
 * WHT memory controller
 * Master FSM and stage counter, bank port muxes, core operand
 * routing and output register around two parity banks
 */
`timescale 1ns/1ps

module wht_mem_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  wht_pkg::sink_beat_t in_beat,
	input  wht_pkg::pair_t      from_core,
	output wht_pkg::pair_t      to_core,
	output wht_pkg::out_beat_t  out_beat,
	output logic                sink_ready
);
	import wht_pkg::*;

	mem_state_t state;
	mem_state_t state_nxt;
	sink_beat_t beat_r;
	log_t       size_r;
	log_t       stage;
	logic       accept;
	ram_wr_t    sink_wr0, sink_wr1, stw_wr0, stw_wr1, wr0, wr1;
	ram_rd_t    srd_rd0, srd_rd1, src_rd0, src_rd1, rd0, rd1;
	word_t      q0, q1;
	logic       sink_done, over_time;
	addr_t      pair_lo;
	logic       lo_bank, issue, rd_end, wr_end;
	logic       lo_bank_d, issue_d;
	logic       bank_sel, src_first, src_last, src_read, source_end;

	// Only a sop in Idle opens a packet
	assign accept = (state == Idle) && in_beat.valid && in_beat.sop;

	// Input register, beats outside Idle and Sink dropped
	always_ff @(posedge clk) begin
		beat_r <= in_beat;
		if (!rst_n) begin
			beat_r.valid <= 1'b0;
			size_r       <= '0;
		end else begin
			beat_r.valid <= in_beat.valid && (accept || state == Sink);
			if (accept) begin
				size_r <= in_beat.size;
			end
		end
	end

	// ------------------------------
	// Master FSM
	// ------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			Idle:        if (accept) state_nxt = Sink;
			Sink:        if (sink_done) state_nxt = Rd;
			             else if (over_time) state_nxt = Idle;
			Rd:          if (rd_end) state_nxt = Wait_wr_end;
			// Last stage goes straight to Source
			Wait_wr_end: if (wr_end) state_nxt = (stage == size_r - 1'b1) ? Source : Rd;
			Source:      if (source_end) state_nxt = Idle;
			default:     state_nxt = Idle;
		endcase
	end

	always_ff @(posedge clk) begin
		lo_bank_d <= lo_bank;
		if (!rst_n) begin
			state      <= Idle;
			stage      <= '0;
			sink_ready <= 1'b1;
			issue_d    <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == Idle) begin
				stage <= '0;
			end else if (state == Wait_wr_end && wr_end && state_nxt == Rd) begin
				stage <= stage + 1'b1;
			end
			// Drops with the accepting edge, rises a cycle into Idle
			sink_ready <= (state == Idle) && (state_nxt == Idle);
			issue_d    <= issue;
		end
	end

	// Bank port muxes
	assign wr0 = (state == Sink) ? sink_wr0 : stw_wr0;
	assign wr1 = (state == Sink) ? sink_wr1 : stw_wr1;
	assign rd0 = (state == Rd) ? srd_rd0 : src_rd0;
	assign rd1 = (state == Rd) ? srd_rd1 : src_rd1;

	// Lower point feeds a
	assign to_core = '{valid: issue_d, a: lo_bank_d ? q1 : q0, b: lo_bank_d ? q0 : q1};

	// Output register
	always_ff @(posedge clk) begin
		out_beat.data <= bank_sel ? q1 : q0;
		if (!rst_n) begin
			out_beat.valid <= 1'b0;
			out_beat.sop   <= 1'b0;
			out_beat.eop   <= 1'b0;
		end else begin
			out_beat.valid <= src_read;
			out_beat.sop   <= src_first;
			out_beat.eop   <= src_last;
		end
	end

	// ------------------------------
	// Banks and generators
	// ------------------------------
	wht_bank_ram i_bank0 (.clk(clk), .wr(wr0), .rd(rd0), .q(q0));
	wht_bank_ram i_bank1 (.clk(clk), .wr(wr1), .rd(rd1), .q(q1));

	wht_sink_addr i_sink_addr (
		.clk(clk), .rst_n(rst_n), .state(state), .beat(beat_r), .size(size_r),
		.wr0(sink_wr0), .wr1(sink_wr1), .sink_done(sink_done), .over_time(over_time)
	);

	wht_stage_rd i_stage_rd (
		.clk(clk), .rst_n(rst_n), .state(state), .stage(stage), .size(size_r),
		.rd0(srd_rd0), .rd1(srd_rd1), .pair_lo(pair_lo), .lo_bank(lo_bank),
		.issue(issue), .rd_end(rd_end)
	);

	wht_stage_wr i_stage_wr (
		.clk(clk), .rst_n(rst_n), .issue(issue), .pair_lo(pair_lo), .stage(stage),
		.result(from_core), .wr0(stw_wr0), .wr1(stw_wr1), .wr_end(wr_end)
	);

	wht_source i_source (
		.clk(clk), .rst_n(rst_n), .state(state), .size(size_r),
		.rd0(src_rd0), .rd1(src_rd1), .bank_sel(bank_sel), .first(src_first),
		.last(src_last), .read(src_read), .source_end(source_end)
	);

endmodule

/* design/wht_pkg.sv */
/*
 * WHT engine shared definitions
 * Widths, state encoding, beat structs and RAM port structs
 */
package wht_pkg;

	// ------------------------------
	// Sizes
	// ------------------------------
	// Largest transform is 2**MAX_LOG points
	localparam int MAX_LOG      = 5;
	localparam int ADDR_W       = MAX_LOG;
	// Bank row drops the parity bit
	localparam int ROW_W        = ADDR_W - 1;
	localparam int SAMPLE_W     = 16;
	// Room for one bit of growth per stage
	localparam int WORD_W       = 24;
	// Idle cycles tolerated inside a packet
	localparam int SINK_TIMEOUT = 64;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [WORD_W-1:0]   word_t;
	typedef logic [ADDR_W-1:0]          addr_t;
	typedef logic [ROW_W-1:0]           row_t;
	// Size, also the stage count
	typedef logic [2:0]                 log_t;

	// Master FSM
	typedef enum logic [2:0] {
		Idle        = 3'd0,
		Sink        = 3'd1,
		Rd          = 3'd2,
		Wait_wr_end = 3'd3,
		Source      = 3'd4
	} mem_state_t;

	// ------------------------------
	// Beats and ports
	// ------------------------------
	typedef struct packed {
		logic    valid;
		logic    sop;
		log_t    size;
		sample_t data;
	} sink_beat_t;

	typedef struct packed {
		logic  valid;
		logic  sop;
		logic  eop;
		word_t data;
	} out_beat_t;

	// Butterfly operands or results
	typedef struct packed {
		logic  valid;
		word_t a;
		word_t b;
	} pair_t;

	typedef struct packed {
		logic  en;
		row_t  row;
		word_t data;
	} ram_wr_t;

	typedef struct packed {
		logic en;
		row_t row;
	} ram_rd_t;

endpackage

/* design/wht_sink_addr.sv */
/*
 * Sink address generator
 * Writes incoming samples in address order into the parity banks,
 * flags the last sample and an input timeout
 */
`timescale 1ns/1ps

module wht_sink_addr (
	input  logic                clk,
	input  logic                rst_n,
	input  wht_pkg::mem_state_t state,
	input  wht_pkg::sink_beat_t beat,
	input  wht_pkg::log_t       size,
	output wht_pkg::ram_wr_t    wr0,
	output wht_pkg::ram_wr_t    wr1,
	output logic                sink_done,
	output logic                over_time
);
	import wht_pkg::*;

	addr_t cnt;
	addr_t last_addr;
	// Counts up to SINK_TIMEOUT inclusive
	logic [$clog2(SINK_TIMEOUT):0] gap;
	logic  bank;
	logic  wr_en;
	word_t data_ext;

	assign last_addr = addr_t'((1 << size) - 1);
	// Bank is address parity
	assign bank      = ^cnt;
	assign wr_en     = (state == Sink) && beat.valid;
	// Sign extend into storage width
	assign data_ext  = {{(WORD_W - SAMPLE_W){beat.data[SAMPLE_W-1]}}, beat.data};

	assign wr0 = '{en: wr_en && !bank, row: cnt[ADDR_W-1:1], data: data_ext};
	assign wr1 = '{en: wr_en && bank, row: cnt[ADDR_W-1:1], data: data_ext};

	assign sink_done = wr_en && (cnt == last_addr);
	assign over_time = (state == Sink) && (gap == SINK_TIMEOUT);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
			gap <= '0;
		end else begin
			// Sample index, restarts outside Sink
			if (state != Sink) begin
				cnt <= '0;
			end else if (beat.valid) begin
				cnt <= cnt + 1'b1;
			end
			// Gap since last valid beat
			if (state != Sink || beat.valid) begin
				gap <= '0;
			end else begin
				gap <= gap + 1'b1;
			end
		end
	end

endmodule

/* design/wht_source.sv */
/*
 * Source address generator
 * Reads the result in natural order and frames the output stream
 */
`timescale 1ns/1ps

module wht_source (
	input  logic                clk,
	input  logic                rst_n,
	input  wht_pkg::mem_state_t state,
	input  wht_pkg::log_t       size,
	output wht_pkg::ram_rd_t    rd0,
	output wht_pkg::ram_rd_t    rd1,
	output logic                bank_sel,
	output logic                first,
	output logic                last,
	output logic                read,
	output logic                source_end
);
	import wht_pkg::*;

	addr_t k;
	addr_t last_addr;
	logic  read_now;
	logic  rd_bank;

	assign read_now   = (state == Source);
	assign last_addr  = addr_t'((1 << size) - 1);
	assign rd_bank    = ^k;
	assign source_end = read_now && (k == last_addr);

	// Only the bank holding point k is read
	assign rd0 = '{en: read_now && !rd_bank, row: k[ADDR_W-1:1]};
	assign rd1 = '{en: read_now && rd_bank, row: k[ADDR_W-1:1]};

	// Framing lags one cycle, in step with RAM output
	always_ff @(posedge clk) begin
		bank_sel <= rd_bank;
		if (!rst_n) begin
			k     <= '0;
			read  <= 1'b0;
			first <= 1'b0;
			last  <= 1'b0;
		end else begin
			k     <= read_now ? k + 1'b1 : '0;
			read  <= read_now;
			first <= read_now && (k == '0);
			last  <= source_end;
		end
	end

endmodule

/* design/wht_stage_rd.sv */
/*
 * Stage read generator
 * Issues one butterfly pair per cycle in Rd, pair points differ
 * only in the stage bit, and flags the last issue
 */
`timescale 1ns/1ps

module wht_stage_rd (
	input  logic                clk,
	input  logic                rst_n,
	input  wht_pkg::mem_state_t state,
	input  wht_pkg::log_t       stage,
	input  wht_pkg::log_t       size,
	output wht_pkg::ram_rd_t    rd0,
	output wht_pkg::ram_rd_t    rd1,
	output wht_pkg::addr_t      pair_lo,
	output logic                lo_bank,
	output logic                issue,
	output logic                rd_end
);
	import wht_pkg::*;

	row_t  pcnt;
	row_t  last_pair;
	addr_t pext;
	addr_t low_mask;
	addr_t lo;
	addr_t hi;

	assign issue     = (state == Rd);
	// Half as many pairs as points
	assign last_pair = row_t'(((1 << size) >> 1) - 1);
	assign rd_end    = issue && (pcnt == last_pair);

	// ------------------------------
	// Pair index to point addresses
	// ------------------------------
	assign pext     = addr_t'(pcnt);
	assign low_mask = addr_t'((1 << stage) - 1);
	// Open a zero at the stage bit
	assign lo       = ((pext & ~low_mask) << 1) | (pext & low_mask);
	assign hi       = lo | addr_t'(1 << stage);

	// The other point always sits in the other bank
	assign lo_bank = ^lo;
	assign pair_lo = lo;

	assign rd0 = '{en: issue, row: lo_bank ? hi[ADDR_W-1:1] : lo[ADDR_W-1:1]};
	assign rd1 = '{en: issue, row: lo_bank ? lo[ADDR_W-1:1] : hi[ADDR_W-1:1]};

	// Restarts on each entry to Rd
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pcnt <= '0;
		end else if (!issue) begin
			pcnt <= '0;
		end else begin
			pcnt <= pcnt + 1'b1;
		end
	end

endmodule

/* design/wht_stage_wr.sv */
/*
 * Stage write generator
 * Aligns pair addresses with read and core latency, writes results
 * back in place and flags the last write of a stage
 */
`timescale 1ns/1ps

module wht_stage_wr (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             issue,
	input  wht_pkg::addr_t   pair_lo,
	input  wht_pkg::log_t    stage,
	input  wht_pkg::pair_t   result,
	output wht_pkg::ram_wr_t wr0,
	output wht_pkg::ram_wr_t wr1,
	output logic             wr_end
);
	import wht_pkg::*;

	addr_t lo_d1;
	addr_t lo_d2;
	addr_t hi;
	logic  v1;
	logic  v2;
	logic  last2;
	logic  lo_bank;
	logic  en;

	always_ff @(posedge clk) begin
		lo_d1 <= pair_lo;
		lo_d2 <= lo_d1;
		if (!rst_n) begin
			v1    <= 1'b0;
			v2    <= 1'b0;
			last2 <= 1'b0;
		end else begin
			v1    <= issue;
			v2    <= v1;
			// Issues are back to back, so a gap marks the last pair
			last2 <= v1 && !issue;
		end
	end

	// Stage holds until the last write is done
	assign hi      = lo_d2 | addr_t'(1 << stage);
	assign lo_bank = ^lo_d2;
	assign en      = v2 && result.valid;

	// a back to the lower point, b to the upper
	assign wr0 = '{en: en,
		row: lo_bank ? hi[ADDR_W-1:1] : lo_d2[ADDR_W-1:1],
		data: lo_bank ? result.b : result.a};
	assign wr1 = '{en: en,
		row: lo_bank ? lo_d2[ADDR_W-1:1] : hi[ADDR_W-1:1],
		data: lo_bank ? result.a : result.b};

	assign wr_end = en && last2;

endmodule

/* src.f */
design/wht_pkg.sv
design/wht_bank_ram.sv
design/wht_sink_addr.sv
design/wht_stage_rd.sv
design/wht_butterfly.sv
design/wht_stage_wr.sv
design/wht_source.sv
design/wht_mem_ctrl.sv
design/wht_engine.sv
test/wht_assert.sv
test/tb_wht.sv

/* test/tb_wht.sv */
/*
 * WHT engine testbench
 * Random and full-scale packets of every size against an integer
 * model, plus busy sop, sink timeout and input gap cases
 */
`timescale 1ns/1ps

module tb_wht;
	import wht_pkg::*;

	// Twelve worst-case packets near 172 cycles plus the timeout case
	localparam int CYCLE_LIMIT = 4000;

	logic       clk;
	logic       rst_n;
	sink_beat_t in_beat;
	out_beat_t  out_beat;
	logic       sink_ready;

	logic [15:0] lfsr = 16'd45;
	int cycles = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int failed = 0;
	int out_count = 0;
	int exp_outputs = 0;
	int samples [0:31];
	int expect_q [0:31];

	wht_engine i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_beat    (in_beat),
		.out_beat   (out_beat),
		.sink_ready (sink_ready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Run limit
	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Run stopped after %0d cycles, tests did not finish", cycles);
		$display("Test failed");
		$finish;
	end

	// Counts every output beat whether wanted or not
	always @(negedge clk) begin
		if (rst_n && out_beat.valid) begin
			out_count++;
		end
	end

	// ------------------------------
	// Helpers
	// ------------------------------
	// Galois LFSR with taps 0xB400 stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
		end
		return v;
	endfunction

	// Value mismatches and bound checker failures together
	function automatic int fault_count();
		return errors + i_dut.i_mem_ctrl.i_assert.fail_count;
	endfunction

	task automatic check_value(input string name, input int exp, input int got);
		checks++;
		assert (got == exp) else begin
			$display("ERROR %0t %s expected %0d got %0d", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic fill_random(input int size);
		for (int i = 0; i < (1 << size); i++) begin
			samples[i] = int'(sample_t'(rand_bits(16)));
		end
	endtask

	// In-place butterflies where stage s pairs i with i + 2**s
	task automatic compute_wht(input int size);
		int a;
		int b;
		for (int i = 0; i < (1 << size); i++) begin
			expect_q[i] = samples[i];
		end
		for (int s = 0; s < size; s++) begin
			for (int i = 0; i < (1 << size); i++) begin
				if (((i >> s) & 1) == 0) begin
					a = expect_q[i];
					b = expect_q[i + (1 << s)];
					expect_q[i] = a + b;
					expect_q[i + (1 << s)] = a - b;
				end
			end
		end
	endtask

	// Waits for sink_ready and then sends one sample per beat
	task automatic send_packet(input int size, input int count, input bit gaps);
		int gap;
		while (!sink_ready) begin
			@(negedge clk);
		end
		for (int i = 0; i < count; i++) begin
			gap = (gaps && i > 0) ? int'(rand_bits(2)) : 0;
			repeat (gap) begin
				in_beat = '0;
				@(negedge clk);
				check_value("sink_ready", 0, sink_ready);
			end
			in_beat = '{valid: 1'b1, sop: (i == 0), size: log_t'(size),
				data: sample_t'(samples[i])};
			@(negedge clk);
			check_value("sink_ready", 0, sink_ready);
		end
		in_beat = '0;
	endtask

	// Next 2**size output beats against the model
	task automatic collect_packet(input int size);
		int n;
		n = 1 << size;
		for (int k = 0; k < n; k++) begin
			@(negedge clk);
			while (!out_beat.valid) begin
				@(negedge clk);
			end
			check_value("out_beat.data", expect_q[k], int'(out_beat.data));
			check_value("out_beat.sop", k == 0, out_beat.sop);
			check_value("out_beat.eop", k == n - 1, out_beat.eop);
			if (k != n - 1) begin
				check_value("sink_ready", 0, sink_ready);
			end
		end
		exp_outputs += n;
	endtask

	task automatic run_size(input int size, input bit gaps);
		fill_random(size);
		compute_wht(size);
		send_packet(size, 1 << size, gaps);
		collect_packet(size);
	endtask

	task automatic end_test(input string name, input int faults_before);
		tests++;
		if (fault_count() == faults_before) begin
			$display("%s: pass", name);
		end else begin
			failed++;
			$display("%s: FAIL", name);
		end
	endtask

	// ------------------------------
	// Sequence
	// ------------------------------
	initial begin
		int e0;
		int wait_n;
		int total;
		rst_n   = 1'b0;
		in_beat = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		e0 = fault_count();
		repeat (8) begin
			@(negedge clk);
			check_value("sink_ready", 1, sink_ready);
			check_value("out_beat.valid", 0, out_beat.valid);
		end
		end_test("reset state", e0);

		e0 = fault_count();
		run_size(3, 1'b0);
		end_test("size 3 random packet", e0);

		e0 = fault_count();
		run_size(1, 1'b0);
		run_size(2, 1'b0);
		run_size(4, 1'b0);
		// Full-scale negative input gives the largest growth into X[0]
		for (int i = 0; i < 32; i++) begin
			samples[i] = -32768;
		end
		compute_wht(5);
		send_packet(5, 32, 1'b0);
		collect_packet(5);
		end_test("sizes 1 2 4 5", e0);

		// Stray sop lands in the stage phase
		e0 = fault_count();
		fill_random(3);
		compute_wht(3);
		send_packet(3, 8, 1'b0);
		repeat (3) @(negedge clk);
		check_value("sink_ready", 0, sink_ready);
		in_beat = '{valid: 1'b1, sop: 1'b1, size: log_t'(1),
			data: sample_t'(rand_bits(16))};
		@(negedge clk);
		in_beat = '0;
		collect_packet(3);
		repeat (10) @(negedge clk);
		check_value("output beat count", exp_outputs, out_count);
		run_size(2, 1'b0);
		end_test("sop while busy", e0);

		// Abandon after three samples
		e0 = fault_count();
		fill_random(3);
		send_packet(3, 3, 1'b0);
		wait_n = 0;
		while (!sink_ready) begin
			@(negedge clk);
			wait_n++;
		end
		checks++;
		assert (wait_n >= SINK_TIMEOUT && wait_n <= SINK_TIMEOUT + 8) else begin
			$display("sink_ready came back after %0d idle cycles, outside the timeout window",
				wait_n);
			errors++;
		end
		check_value("output beat count", exp_outputs, out_count);
		run_size(3, 1'b0);
		end_test("sink timeout", e0);

		e0 = fault_count();
		run_size(4, 1'b1);
		run_size(5, 1'b1);
		end_test("input gaps", e0);

		repeat (10) @(negedge clk);
		check_value("output beat count", exp_outputs, out_count);
		total = fault_count();
		$display("Tests run %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
			tests, failed, checks, errors, i_dut.i_mem_ctrl.i_assert.fail_count);
		if (failed == 0 && total == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* test/wht_assert.sv */
/*
 * WHT memory controller protocol checks
 * Bound into the controller, watches output framing, bank writes,
 * state encoding and sink_ready
 */
`timescale 1ns/1ps

module wht_assert (
	input logic                clk,
	input logic                rst_n,
	input wht_pkg::mem_state_t state,
	input wht_pkg::ram_wr_t    wr0,
	input wht_pkg::ram_wr_t    wr1,
	input wht_pkg::out_beat_t  out_beat,
	input logic                sink_ready
);
	import wht_pkg::*;

	// Failures so far, read by the testbench
	int fail_count = 0;

	// Output trails the Source reads by RAM and output register
	out_in_source: assert property (@(posedge clk) disable iff (!rst_n)
		out_beat.valid |-> (state == Source || $past(state) == Source
			|| $past(state, 2) == Source))
	else begin
		$error("output beat valid outside Source and its two trailing cycles");
		fail_count++;
	end

	// Banks only read while streaming out
	no_write_in_source: assert property (@(posedge clk) disable iff (!rst_n)
		(state == Source) |-> !(wr0.en || wr1.en))
	else begin
		$error("bank written during Source");
		fail_count++;
	end

	legal_state: assert property (@(posedge clk) disable iff (!rst_n)
		state inside {Idle, Sink, Rd, Wait_wr_end, Source})
	else begin
		$error("FSM state outside its legal values");
		fail_count++;
	end

	ready_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
		sink_ready |-> (state == Idle))
	else begin
		$error("sink_ready high while FSM is not Idle");
		fail_count++;
	end

endmodule

bind wht_mem_ctrl wht_assert i_assert (
	.clk        (clk),
	.rst_n      (rst_n),
	.state      (state),
	.wr0        (wr0),
	.wr1        (wr1),
	.out_beat   (out_beat),
	.sink_ready (sink_ready)
);
